// File: rtl/rv_regfile_cfg.svh
`ifndef RV_REGFILE_CFG_SVH
`define RV_REGFILE_CFG_SVH

// Counter halves, read-only window 0x20..0x27
`define RV_CSR_MCYCLE     6'h20
`define RV_CSR_MCYCLEH    6'h21
`define RV_CSR_MINSTRET   6'h22
`define RV_CSR_MINSTRETH  6'h23

// Machine trap vector
`define RV_CSR_MTVEC      6'h24

// DEP bounds, also mirrored in the array
`define RV_CSR_DEP_LO     6'h30
`define RV_CSR_DEP_HI     6'h31

// Write here to pulse the soft-reset request
`define RV_CSR_SOFT_RESET 6'h32

// DEP feature switch and lock bit position
`define RV_ENABLE_DEP     1
`define RV_DEP_LOCK_BIT   1

`define RV_REG_DEPTH      64
`endif

// File: rtl/rv_regfile_pkg.sv
package rv_regfile_pkg;

	// Basic data word
	typedef logic [31:0] word_t;

	// Full 64-bit counter value
	typedef logic [63:0] dword_t;

	// Register-space address
	// 0x00..0x1F general registers, 0x20..0x3F CSR window
	typedef logic [5:0] reg_addr_t;

	// Single write port
	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     data;
	} wr_req_t;

	// Live CSR values seen through read port B
	typedef struct packed {
		dword_t mcycle;
		dword_t minstret;
		word_t  mtvec;
	} csr_view_t;

	// Execute-protection window bounds
	typedef struct packed {
		word_t lo;
		word_t hi;
	} dep_window_t;

	// Upper bits that select the read-only CSR block (0x20..0x27)
	localparam logic [2:0] RO_BLOCK = 3'b100;

	// Width of one counter half
	localparam int HALF_W = 32;

endpackage

// File: rtl/csr_counter64.sv
`timescale 1ns/1ns
`include "rv_regfile_cfg.svh"

// 64-bit CSR counter
// Software can overwrite either 32-bit half through the write port
module csr_counter64 import rv_regfile_pkg::*; #(
	parameter reg_addr_t LO_ADDR = `RV_CSR_MCYCLE,
	parameter reg_addr_t HI_ADDR = `RV_CSR_MCYCLEH
) (
	input  logic    clock,
	input  logic    reset,
	input  wr_req_t wr,
	input  logic    count_en,
	output dword_t  count
);

	// Address hits on each half
	logic   hit_lo;
	logic   hit_hi;

	// Counter value after this edge
	dword_t count_next;

	// Incremented value, carry from low to high half handled by the adder
	dword_t count_inc;

	assign hit_lo = wr.en && (wr.addr == LO_ADDR);
	assign hit_hi = wr.en && (wr.addr == HI_ADDR);

	assign count_inc = count + 64'd1;

	// Next-state selection
	// A write to either half wins over the increment
	always_comb begin
		count_next = count;
		if (hit_lo) begin
			count_next = {count[63:HALF_W], wr.data};
		end else if (hit_hi) begin
			count_next = {wr.data, count[HALF_W-1:0]};
		end else if (count_en) begin
			count_next = count_inc;
		end
	end

	// Counter register
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count_next;
		end
	end

endmodule

// File: rtl/csr_control.sv
`timescale 1ns/1ns
`include "rv_regfile_cfg.svh"

// Machine control CSRs
// DEP bounds with self-locking, writable mtvec, soft-reset request decode
module csr_control import rv_regfile_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  wr_req_t     wr,
	output dep_window_t dep,
	output word_t       mtvec,
	output logic        soft_reset_req
);

	// Stored DEP bounds
	dep_window_t dep_q;

	// Lock state comes straight from the stored enable bits
	logic lo_locked;
	logic hi_locked;

	// Write decodes
	logic wr_dep_lo;
	logic wr_dep_hi;
	logic wr_mtvec;

	assign lo_locked = dep_q.lo[`RV_DEP_LOCK_BIT];
	assign hi_locked = dep_q.hi[`RV_DEP_LOCK_BIT];

	// A bound only takes writes until its lock bit is set
	assign wr_dep_lo = wr.en && (wr.addr == `RV_CSR_DEP_LO) && !lo_locked;
	assign wr_dep_hi = wr.en && (wr.addr == `RV_CSR_DEP_HI) && !hi_locked;
	assign wr_mtvec  = wr.en && (wr.addr == `RV_CSR_MTVEC);

	// DEP bound registers
	// Once locked they hold until reset
	always_ff @(posedge clock) begin
		if (reset) begin
			dep_q <= '0;
		end else begin
			if (wr_dep_lo) begin
				dep_q.lo <= wr.data;
			end
			if (wr_dep_hi) begin
				dep_q.hi <= wr.data;
			end
		end
	end

	// Trap vector, no lock
	always_ff @(posedge clock) begin
		if (reset) begin
			mtvec <= '0;
		end else if (wr_mtvec) begin
			mtvec <= wr.data;
		end
	end

	// Feature switch, DEP window reads zero when disabled
	assign dep = (`RV_ENABLE_DEP != 0) ? dep_q : '0;

	// Request pulse lasts exactly the cycle of the write
	assign soft_reset_req = wr.en && (wr.addr == `RV_CSR_SOFT_RESET);

endmodule

// File: rtl/reg_bank.sv
`timescale 1ns/1ns
`include "rv_regfile_cfg.svh"

// 64 x 32 register array
// Two synchronous read ports, port B also sees the live CSR values
module reg_bank import rv_regfile_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  wr_req_t   wr,
	input  csr_view_t csr,
	input  reg_addr_t ra_addr,
	output word_t     ra_rdata,
	input  reg_addr_t rb_addr,
	output word_t     rb_rdata
);

	// Register storage, x0..x31 then the CSR window
	word_t regs [0:`RV_REG_DEPTH-1];

	// Write gating
	logic wr_is_x0;
	logic wr_is_ro;
	logic wr_ok;

	// Port B source before the output register
	word_t rb_next;

	// x0 is hardwired to zero
	assign wr_is_x0 = (wr.addr == '0);

	// Counter window 0x20..0x27 is read-only in the array
	assign wr_is_ro = (wr.addr[5:3] == RO_BLOCK);

	assign wr_ok = wr.en && !wr_is_x0 && !wr_is_ro;

	// Array update
	// DEP addresses land here too, so the copy takes every write
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RV_REG_DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// Port B select
	// Counters and mtvec come from the live view, everything else from the array
	always_comb begin
		case (rb_addr)
			`RV_CSR_MCYCLE: begin
				rb_next = csr.mcycle[HALF_W-1:0];
			end
			`RV_CSR_MCYCLEH: begin
				rb_next = csr.mcycle[63:HALF_W];
			end
			`RV_CSR_MINSTRET: begin
				rb_next = csr.minstret[HALF_W-1:0];
			end
			`RV_CSR_MINSTRETH: begin
				rb_next = csr.minstret[63:HALF_W];
			end
			`RV_CSR_MTVEC: begin
				rb_next = csr.mtvec;
			end
			default: begin
				rb_next = regs[rb_addr];
			end
		endcase
	end

	// Read output registers
	// A same-edge write is not bypassed, so the old value comes out
	always_ff @(posedge clock) begin
		if (reset) begin
			ra_rdata <= '0;
			rb_rdata <= '0;
		end else begin
			ra_rdata <= regs[ra_addr];
			rb_rdata <= rb_next;
		end
	end

endmodule

// File: rtl/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_regfile_cfg.svh"

// Register file and machine CSR block
// Ties the two counters, the control CSRs and the register array together
module rv_regfile import rv_regfile_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  wr_req_t     wr,
	input  logic        instr_complete,
	input  reg_addr_t   ra_addr,
	output word_t       ra_rdata,
	input  reg_addr_t   rb_addr,
	output word_t       rb_rdata,
	output dep_window_t dep,
	output word_t       mtvec,
	output logic        soft_reset_req
);

	// Live CSR values for port B
	csr_view_t csr_view;

	// mcycle / mcycleh counts every edge
	csr_counter64 #(
		.LO_ADDR (`RV_CSR_MCYCLE),
		.HI_ADDR (`RV_CSR_MCYCLEH)
	) u_mcycle (
		.clock    (clock),
		.reset    (reset),
		.wr       (wr),
		.count_en (1'b1),
		.count    (csr_view.mcycle)
	);

	// minstret / minstreth counts completed instructions
	csr_counter64 #(
		.LO_ADDR (`RV_CSR_MINSTRET),
		.HI_ADDR (`RV_CSR_MINSTRETH)
	) u_minstret (
		.clock    (clock),
		.reset    (reset),
		.wr       (wr),
		.count_en (instr_complete),
		.count    (csr_view.minstret)
	);

	// DEP bounds, mtvec, soft reset
	csr_control u_csr_control (
		.clock          (clock),
		.reset          (reset),
		.wr             (wr),
		.dep            (dep),
		.mtvec          (mtvec),
		.soft_reset_req (soft_reset_req)
	);

	// mtvec is both a top output and part of the port B view
	assign csr_view.mtvec = mtvec;

	// Register array with both read ports
	reg_bank u_reg_bank (
		.clock    (clock),
		.reset    (reset),
		.wr       (wr),
		.csr      (csr_view),
		.ra_addr  (ra_addr),
		.ra_rdata (ra_rdata),
		.rb_addr  (rb_addr),
		.rb_rdata (rb_rdata)
	);

endmodule

// File: tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Stimulus table, one row per clock cycle
// Columns: wr_en, wr_addr, random data, wr_data, instr_complete, ra_addr, rb_addr, check reads
task automatic fill_table();
	// Quiet sweep of the whole space right after reset
	for (int i = 0; i < 64; i++) begin
		add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'(i), 6'(63 - i), 1'b1);
	end

	// x1..x31 with random data, each one read back on the next row
	for (int i = 1; i < 32; i++) begin
		add_row(1'b1, 6'(i), 1'b1, 32'h0, 1'b0, 6'(i - 1), 6'(i - 1), 1'b1);
	end
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'h1f, 6'h1e, 1'b1);

	// Read and write of x5 on the same edge, old value first
	add_row(1'b1, 6'h05, 1'b0, 32'hcafe_0005, 1'b0, 6'h05, 6'h05, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'h05, 6'h05, 1'b1);

	// x0 and the read-only window keep the array unchanged
	add_row(1'b1, 6'h00, 1'b1, 32'h0, 1'b0, 6'h00, 6'h00, 1'b1);
	add_row(1'b1, 6'h25, 1'b0, 32'h5555_aaaa, 1'b0, 6'h00, 6'h00, 1'b1);
	add_row(1'b1, 6'h27, 1'b1, 32'h0, 1'b0, 6'h25, 6'h25, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'h27, 6'h27, 1'b1);

	// mcycle low half near wrap, then watch the carry into the high half
	add_row(1'b1, `RV_CSR_MCYCLE, 1'b0, 32'hffff_fffc, 1'b0, 6'h00, `RV_CSR_MCYCLEH, 1'b1);
	for (int i = 0; i < 8; i++) begin
		add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, `RV_CSR_MCYCLE,
			(i % 2 == 0) ? `RV_CSR_MCYCLE : `RV_CSR_MCYCLEH, 1'b1);
	end
	add_row(1'b1, `RV_CSR_MCYCLEH, 1'b0, 32'h0000_1234, 1'b0, 6'h00, `RV_CSR_MCYCLE, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'h00, `RV_CSR_MCYCLEH, 1'b1);
	add_row(1'b1, `RV_CSR_MCYCLEH, 1'b1, 32'h0, 1'b0, 6'h00, `RV_CSR_MCYCLE, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'h00, `RV_CSR_MCYCLEH, 1'b1);

	// minstret, the strobe on the write row is swallowed by the write
	add_row(1'b1, `RV_CSR_MINSTRET, 1'b0, 32'hffff_fffe, 1'b1, 6'h00, `RV_CSR_MINSTRET, 1'b1);
	for (int i = 0; i < 8; i++) begin
		add_row(1'b0, 6'h00, 1'b0, 32'h0, (i % 3 != 2), `RV_CSR_MINSTRET,
			(i % 2 == 0) ? `RV_CSR_MINSTRET : `RV_CSR_MINSTRETH, 1'b1);
	end
	add_row(1'b1, `RV_CSR_MINSTRETH, 1'b1, 32'h0, 1'b1, 6'h00, `RV_CSR_MINSTRETH, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b1, 6'h00, `RV_CSR_MINSTRETH, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'h00, `RV_CSR_MINSTRET, 1'b1);

	// Trap vector, output and port B
	add_row(1'b1, `RV_CSR_MTVEC, 1'b0, 32'h8000_0100, 1'b0, 6'h00, `RV_CSR_MTVEC, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, `RV_CSR_MTVEC, `RV_CSR_MTVEC, 1'b1);
	add_row(1'b1, `RV_CSR_MTVEC, 1'b1, 32'h0, 1'b0, 6'h00, `RV_CSR_MTVEC, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'h00, `RV_CSR_MTVEC, 1'b1);

	// Soft reset pulse lasts only the write cycle
	add_row(1'b1, `RV_CSR_SOFT_RESET, 1'b1, 32'h0, 1'b0, 6'h32, 6'h32, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'h32, 6'h32, 1'b1);

	// DEP low bound, rewrite, lock, then an ignored write
	add_row(1'b1, `RV_CSR_DEP_LO, 1'b0, 32'h0000_1000, 1'b0, 6'h30, 6'h30, 1'b1);
	add_row(1'b1, `RV_CSR_DEP_LO, 1'b0, 32'h0000_2000, 1'b0, 6'h30, 6'h30, 1'b1);
	add_row(1'b1, `RV_CSR_DEP_LO, 1'b0, 32'h0000_3002, 1'b0, 6'h30, 6'h30, 1'b1);
	add_row(1'b1, `RV_CSR_DEP_LO, 1'b0, 32'h0000_4000, 1'b0, 6'h30, 6'h30, 1'b1);

	// DEP high bound, same sequence with a random late write
	add_row(1'b1, `RV_CSR_DEP_HI, 1'b0, 32'h0000_f000, 1'b0, 6'h31, 6'h31, 1'b1);
	add_row(1'b1, `RV_CSR_DEP_HI, 1'b0, 32'h0000_f002, 1'b0, 6'h31, 6'h31, 1'b1);
	add_row(1'b1, `RV_CSR_DEP_HI, 1'b1, 32'h0, 1'b0, 6'h31, 6'h31, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'h30, 6'h31, 1'b1);
	add_row(1'b0, 6'h00, 1'b0, 32'h0, 1'b0, 6'h00, 6'h00, 1'b0);
endtask

`endif

// File: tests/tb_rv_regfile.sv
`timescale 1ns/1ns
`include "rv_regfile_cfg.svh"

module tb_rv_regfile import rv_regfile_pkg::*; ();

	localparam int CLK_PERIOD = 40;

	// DUT ports
	logic        clock;
	logic        reset;
	wr_req_t     wr;
	logic        instr_complete;
	reg_addr_t   ra_addr;
	word_t       ra_rdata;
	reg_addr_t   rb_addr;
	word_t       rb_rdata;
	dep_window_t dep;
	word_t       mtvec;
	logic        soft_reset_req;

	// One stimulus row
	typedef struct packed {
		logic      wr_en;
		reg_addr_t wr_addr;
		logic      rnd;
		word_t     wr_data;
		logic      ic;
		reg_addr_t ra;
		reg_addr_t rb;
		logic      chk;
	} row_t;

	row_t   rows[$];
	integer seed;
	int     err_count;
	bit     table_ready;

	// Reference model state
	word_t       mem_ref [0:63];
	logic [63:0] mcycle_ref;
	logic [63:0] minstret_ref;
	word_t       mtvec_ref;
	dep_window_t dep_ref;

	rv_regfile u_rv_regfile (
		.clock          (clock),
		.reset          (reset),
		.wr             (wr),
		.instr_complete (instr_complete),
		.ra_addr        (ra_addr),
		.ra_rdata       (ra_rdata),
		.rb_addr        (rb_addr),
		.rb_rdata       (rb_rdata),
		.dep            (dep),
		.mtvec          (mtvec),
		.soft_reset_req (soft_reset_req)
	);

	`include "tb_vectors.svh"

	task automatic add_row(input logic wr_en, input reg_addr_t wr_addr, input logic rnd,
		input word_t wr_data, input logic ic, input reg_addr_t ra, input reg_addr_t rb,
		input logic chk);
		row_t r;
		r = '{wr_en, wr_addr, rnd, wr_data, ic, ra, rb, chk};
		rows.push_back(r);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			err_count++;
			$display("ERROR %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic clear_model();
		for (int i = 0; i < 64; i++) begin
			mem_ref[i] = '0;
		end
		mcycle_ref   = '0;
		minstret_ref = '0;
		mtvec_ref    = '0;
		dep_ref      = '0;
	endtask

	// Port B view with live counters and mtvec and the array for every other address
	function automatic word_t port_b_ref(input reg_addr_t addr);
		case (addr)
			`RV_CSR_MCYCLE:    port_b_ref = mcycle_ref[31:0];
			`RV_CSR_MCYCLEH:   port_b_ref = mcycle_ref[63:32];
			`RV_CSR_MINSTRET:  port_b_ref = minstret_ref[31:0];
			`RV_CSR_MINSTRETH: port_b_ref = minstret_ref[63:32];
			`RV_CSR_MTVEC:     port_b_ref = mtvec_ref;
			default:           port_b_ref = mem_ref[addr];
		endcase
	endfunction

	// State change at one rising edge
	task automatic model_edge(input logic en, input reg_addr_t addr, input word_t data,
		input logic ic);
		if (en && addr != 6'h00 && !(addr >= 6'h20 && addr <= 6'h27)) begin
			mem_ref[addr] = data;
		end
		// A write to either half replaces it and skips the count
		if (en && addr == `RV_CSR_MCYCLE) begin
			mcycle_ref[31:0] = data;
		end else if (en && addr == `RV_CSR_MCYCLEH) begin
			mcycle_ref[63:32] = data;
		end else begin
			mcycle_ref = mcycle_ref + 64'd1;
		end
		if (en && addr == `RV_CSR_MINSTRET) begin
			minstret_ref[31:0] = data;
		end else if (en && addr == `RV_CSR_MINSTRETH) begin
			minstret_ref[63:32] = data;
		end else if (ic) begin
			minstret_ref = minstret_ref + 64'd1;
		end
		if (en && addr == `RV_CSR_MTVEC) begin
			mtvec_ref = data;
		end
		// Bounds freeze once their lock bit is stored
		if (en && addr == `RV_CSR_DEP_LO && !dep_ref.lo[`RV_DEP_LOCK_BIT]) begin
			dep_ref.lo = data;
		end
		if (en && addr == `RV_CSR_DEP_HI && !dep_ref.hi[`RV_DEP_LOCK_BIT]) begin
			dep_ref.hi = data;
		end
	endtask

	// Drive one row 2 ns after the edge and check 1 ns after the next edge
	task automatic apply_row(input row_t r);
		word_t       data;
		word_t       exp_ra;
		word_t       exp_rb;
		logic        exp_soft;
		dep_window_t exp_dep;
		data = r.rnd ? $random(seed) : r.wr_data;
		wr.en          = r.wr_en;
		wr.addr        = r.wr_addr;
		wr.data        = data;
		instr_complete = r.ic;
		ra_addr        = r.ra;
		rb_addr        = r.rb;
		// Reads see the state held before the edge
		exp_ra   = mem_ref[r.ra];
		exp_rb   = port_b_ref(r.rb);
		exp_soft = r.wr_en && (r.wr_addr == `RV_CSR_SOFT_RESET);
		model_edge(r.wr_en, r.wr_addr, data, r.ic);
		exp_dep = (`RV_ENABLE_DEP != 0) ? dep_ref : '0;
		// The request pulse belongs to the write cycle itself, before the edge
		#1;
		check_word("soft_reset_req", {31'b0, soft_reset_req}, {31'b0, exp_soft});
		@(posedge clock);
		#1;
		if (r.chk) begin
			check_word("ra_rdata", ra_rdata, exp_ra);
			check_word("rb_rdata", rb_rdata, exp_rb);
		end
		check_word("mtvec", mtvec, mtvec_ref);
		check_word("dep.lo", dep.lo, exp_dep.lo);
		check_word("dep.hi", dep.hi, exp_dep.hi);
		#1;
	endtask

	initial begin
		clock = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clock = ~clock;
		end
	end

	// Watchdog sized from the table length
	initial begin
		int unsigned limit_ns;
		wait (table_ready);
		limit_ns = CLK_PERIOD * (rows.size() + 10);
		#(limit_ns);
		$display("Timeout: the table did not finish within %0d ns", limit_ns);
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed           = 32'hda915479;
		err_count      = 0;
		reset          = 1'b1;
		wr             = '0;
		instr_complete = 1'b0;
		ra_addr        = '0;
		rb_addr        = '0;
		fill_table();
		table_ready = 1'b1;
		clear_model();
		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		if (err_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+rtl
+incdir+tests
rtl/rv_regfile_pkg.sv
rtl/csr_counter64.sv
rtl/csr_control.sv
rtl/reg_bank.sv
rtl/rv_regfile.sv
tests/tb_rv_regfile.sv

// File: run.sh
#!/bin/bash
# Build and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_rv_regfile -f vlog.f \
	-o Vtb_rv_regfile > build.log 2>&1 \
	&& ./obj_dir/Vtb_rv_regfile > sim.log 2>&1 \
	|| echo "test failed" >> sim.log
cat sim.log
if grep -q "test failed" sim.log; then
	exit 1
fi
grep -q "test passed" sim.log
